//--- src.f
+incdir+include
logic/slot_pkg.sv
logic/msg_pkg.sv
logic/desc_fifo.sv
logic/slot_recycler.sv
logic/rx_desc_builder.sv
logic/tx_desc_issuer.sv
logic/dma_slot_ctrl.sv
testbench/tb_dma_slot_ctrl.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f src.f --top-module tb_dma_slot_ctrl -o sim_tb &&
./obj_dir/sim_tb || exit 1

//--- testbench/tb_dma_slot_ctrl.sv
`timescale 1ns/1ps
`include "dma_cfg.svh"

module tb_dma_slot_ctrl
  import slot_pkg::*;
();

  logic clk, rst, msg_valid, tx_desc_ready, rx_desc_ready, incoming_pkt, pkt_sent_out;
  logic drop_list_valid, max_pkt_len_valid, slot_addr_wr_valid, inject_desc_valid;
  logic [63:0] msg_data;
  core_no_t msg_core_no, inject_desc_core;
  slot_no_t slot_addr_wr_no, inject_desc_slot;
  slot_addr_t slot_addr_wr_data;
  logic [`CORE_COUNT-1:0] drop_list;
  pkt_len_t max_pkt_len;
  logic msg_ready, tx_desc_valid, rx_desc_valid, inject_desc_ready;
  dma_addr_t tx_desc_addr, rx_desc_addr;
  pkt_len_t tx_desc_len, rx_desc_len;

  // reference model state
  logic [7:0] inflight_q[$];
  logic [7:0] free_q[$];
  slot_addr_t slot_tab [`SLOT_COUNT];
  logic [`CORE_COUNT-1:0] drop_r;
  logic tx_pend, exp_rx_any, stim_on, exp_msg_ready;
  logic [7:0] tx_entry;
  dma_addr_t tx_addr, exp_rx_addr;
  pkt_len_t tx_len, max_len;
  int rx_count, pkt_count, cycles;

  dma_slot_ctrl UUT (.*);

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  assign exp_msg_ready = tx_desc_ready && !tx_pend;

  always @(posedge clk) begin : ref_model
    logic found;
    logic [7:0] head;
    found = 1'b0;
    head = '0;
    if (rst) begin
      inflight_q.delete();
      free_q.delete();
      tx_pend <= 1'b0;
      max_len <= pkt_len_t'(`DEF_MAX_PKT_LEN);
      drop_r = '0;
      rx_count <= 0;
      pkt_count <= 0;
    end else begin
      // an issued descriptor consumes the oldest slot of a core not dropped
      if (rx_desc_valid) begin
        while (free_q.size() > 0 && drop_r[free_q[0][7:4]]) void'(free_q.pop_front());
        if (free_q.size() > 0) void'(free_q.pop_front());
        rx_count <= rx_count + 1;
      end
      if (pkt_sent_out && inflight_q.size() > 0) begin
        free_q.push_back(inflight_q.pop_front());
      end else if (inject_desc_valid && !pkt_sent_out) begin
        free_q.push_back({inject_desc_core, inject_desc_slot});
      end
      if (tx_pend) inflight_q.push_back(tx_entry);
      tx_pend <= msg_valid && exp_msg_ready && (msg_data[15:0] != 16'h0);
      if (msg_valid && exp_msg_ready) begin
        tx_addr <= {msg_core_no, msg_data[47:32]};
        tx_len <= msg_data[15:0];
        tx_entry <= {msg_core_no, msg_data[27:24]};
      end
      if (incoming_pkt) pkt_count <= pkt_count + 1;
      if (max_pkt_len_valid) max_len <= max_pkt_len;
      if (slot_addr_wr_valid) slot_tab[slot_addr_wr_no] = slot_addr_wr_data;
      if (drop_list_valid) drop_r = drop_list;
      for (int i = 0; i < free_q.size(); i++) begin
        if (!found && !drop_r[free_q[i][7:4]]) begin
          found = 1'b1;
          head = free_q[i];
        end
      end
    end
    exp_rx_any <= found;
    exp_rx_addr <= {head[7:4], 1'b0, slot_tab[head[3:0]], `RX_WRITE_OFFSET};
  end

  a_quiet: assert property (@(posedge clk) disable iff (rst)
    !stim_on |-> !tx_desc_valid && !rx_desc_valid)
    else fail_now("descriptor strobe seen before any stimulus");
  a_msg_ready: assert property (@(posedge clk) disable iff (rst) msg_ready == exp_msg_ready)
    else fail_now($sformatf("MISMATCH msg_ready got %h expected %h",
                            $sampled(msg_ready), $sampled(exp_msg_ready)));
  a_tx_valid: assert property (@(posedge clk) disable iff (rst) tx_desc_valid == tx_pend)
    else fail_now($sformatf("MISMATCH tx_desc_valid got %h expected %h",
                            $sampled(tx_desc_valid), $sampled(tx_pend)));
  a_tx_addr: assert property (@(posedge clk) disable iff (rst)
    tx_desc_valid |-> tx_desc_addr == tx_addr)
    else fail_now($sformatf("MISMATCH tx_desc_addr got %h expected %h",
                            $sampled(tx_desc_addr), $sampled(tx_addr)));
  a_tx_len: assert property (@(posedge clk) disable iff (rst)
    tx_desc_valid |-> tx_desc_len == tx_len)
    else fail_now($sformatf("MISMATCH tx_desc_len got %h expected %h",
                            $sampled(tx_desc_len), $sampled(tx_len)));
  // traffic keeps the free queue far below its depth
  a_inject: assert property (@(posedge clk) disable iff (rst)
    inject_desc_ready == !pkt_sent_out)
    else fail_now($sformatf("MISMATCH inject_desc_ready got %h expected %h",
                            $sampled(inject_desc_ready), !$sampled(pkt_sent_out)));
  a_rx_ready: assert property (@(posedge clk) disable iff (rst)
    rx_desc_valid |-> rx_desc_ready)
    else fail_now("rx descriptor issued while rx_desc_ready was low");
  a_rx_pkt: assert property (@(posedge clk) disable iff (rst)
    rx_desc_valid |-> rx_count < pkt_count + int'(incoming_pkt))
    else fail_now("more rx descriptors than incoming packets");
  a_rx_slot: assert property (@(posedge clk) disable iff (rst)
    rx_desc_valid |-> exp_rx_any)
    else fail_now("rx descriptor issued with no usable free slot in the model");
  a_rx_addr: assert property (@(posedge clk) disable iff (rst)
    rx_desc_valid |-> rx_desc_addr == exp_rx_addr)
    else fail_now($sformatf("MISMATCH rx_desc_addr got %h expected %h",
                            $sampled(rx_desc_addr), $sampled(exp_rx_addr)));
  a_rx_len: assert property (@(posedge clk) disable iff (rst)
    rx_desc_valid |-> rx_desc_len == max_len)
    else fail_now($sformatf("MISMATCH rx_desc_len got %h expected %h",
                            $sampled(rx_desc_len), $sampled(max_len)));

  // runs are about 1200 cycles long
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= 4000) fail_now("timeout after 4000 cycles");
  end

  task automatic drive_traffic(input int n);
    msg_valid = (inflight_q.size() + int'(tx_pend) < 4) && ($urandom % 3 == 0);
    msg_core_no = 4'($urandom);
    msg_data = {16'h0, 16'($urandom), 4'h0, 4'($urandom), 8'h0, 16'($urandom)};
    if ($urandom % 8 == 0) msg_data[15:0] = 16'h0;
    tx_desc_ready = ($urandom % 4 != 0);
    pkt_sent_out = (inflight_q.size() > 0) && ($urandom % 3 == 0);
    inject_desc_valid = ($urandom % 8 == 0);
    inject_desc_core = 4'($urandom);
    inject_desc_slot = 4'($urandom);
    incoming_pkt = ($urandom % 4 == 0);
    rx_desc_ready = ($urandom % 4 != 0);
    max_pkt_len_valid = (n == 400);
    max_pkt_len = 16'($urandom) | 16'h0100;
  endtask

  initial begin
    void'($urandom(12507));
    cycles = 0;
    stim_on = 1'b0;
    rst = 1'b1;
    {msg_valid, tx_desc_ready, rx_desc_ready, incoming_pkt, pkt_sent_out} = '0;
    {drop_list_valid, max_pkt_len_valid, slot_addr_wr_valid, inject_desc_valid} = '0;
    {msg_data, msg_core_no, inject_desc_core, inject_desc_slot} = '0;
    {slot_addr_wr_no, slot_addr_wr_data, drop_list, max_pkt_len} = '0;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    repeat (5) @(posedge clk);
    // slot table and drop list are set up before traffic
    for (int i = 0; i < `SLOT_COUNT; i++) begin
      #1;
      slot_addr_wr_valid = 1'b1;
      slot_addr_wr_no = 4'(i);
      slot_addr_wr_data = 7'($urandom);
      drop_list_valid = (i == 0);
      drop_list = 16'h0208;
      @(posedge clk);
    end
    #1 slot_addr_wr_valid = 1'b0;
    drop_list_valid = 1'b0;
    stim_on = 1'b1;
    for (int n = 0; n < 800; n++) begin
      drive_traffic(n);
      @(posedge clk);
      #1;
    end
    // drain both queues
    {msg_valid, inject_desc_valid, max_pkt_len_valid} = '0;
    {rx_desc_ready, incoming_pkt} = 2'b11;
    while (exp_rx_any || tx_pend || inflight_q.size() > 0) begin
      pkt_sent_out = (inflight_q.size() > 0);
      @(posedge clk);
      #1;
    end
    {pkt_sent_out, incoming_pkt} = '0;
    repeat (10) @(posedge clk);
    if (UUT.free_valid) begin
      fail_now("free queue still holds slots after the drain");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

//--- logic/dma_slot_ctrl.sv
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_slot_ctrl
  import slot_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [63:0]            msg_data,
  input  core_no_t               msg_core_no,
  input  logic                   msg_valid,
  output logic                   msg_ready,
  output dma_addr_t              tx_desc_addr,
  output pkt_len_t               tx_desc_len,
  output logic                   tx_desc_valid,
  input  logic                   tx_desc_ready,
  output dma_addr_t              rx_desc_addr,
  output pkt_len_t               rx_desc_len,
  output logic                   rx_desc_valid,
  input  logic                   rx_desc_ready,
  input  logic                   incoming_pkt,
  input  logic                   pkt_sent_out,
  input  logic [`CORE_COUNT-1:0] drop_list,
  input  logic                   drop_list_valid,
  input  pkt_len_t               max_pkt_len,
  input  logic                   max_pkt_len_valid,
  input  slot_no_t               slot_addr_wr_no,
  input  slot_addr_t             slot_addr_wr_data,
  input  logic                   slot_addr_wr_valid,
  input  core_no_t               inject_desc_core,
  input  slot_no_t               inject_desc_slot,
  input  logic                   inject_desc_valid,
  output logic                   inject_desc_ready
);

  core_no_t sent_core;
  slot_no_t sent_slot;
  logic     free_valid;
  core_no_t free_core;
  slot_no_t free_slot;
  logic     free_pop;

  slot_recycler u_recycler (
    .clk(clk), .rst(rst),
    .sent_valid(tx_desc_valid), .sent_core(sent_core), .sent_slot(sent_slot),
    .pkt_sent_out(pkt_sent_out),
    .inject_desc_core(inject_desc_core), .inject_desc_slot(inject_desc_slot),
    .inject_desc_valid(inject_desc_valid), .inject_desc_ready(inject_desc_ready),
    .free_valid(free_valid), .free_core(free_core), .free_slot(free_slot),
    .free_pop(free_pop)
  );

  rx_desc_builder u_rx_builder (
    .clk(clk), .rst(rst),
    .free_valid(free_valid), .free_core(free_core), .free_slot(free_slot),
    .free_pop(free_pop), .incoming_pkt(incoming_pkt),
    .drop_list(drop_list), .drop_list_valid(drop_list_valid),
    .max_pkt_len(max_pkt_len), .max_pkt_len_valid(max_pkt_len_valid),
    .slot_addr_wr_no(slot_addr_wr_no), .slot_addr_wr_data(slot_addr_wr_data),
    .slot_addr_wr_valid(slot_addr_wr_valid), .rx_desc_ready(rx_desc_ready),
    .rx_desc_valid(rx_desc_valid), .rx_desc_addr(rx_desc_addr), .rx_desc_len(rx_desc_len)
  );

  tx_desc_issuer u_tx_issuer (
    .clk(clk), .rst(rst),
    .msg_data(msg_data), .msg_valid(msg_valid), .msg_core_no(msg_core_no),
    .msg_ready(msg_ready), .tx_desc_ready(tx_desc_ready),
    .tx_desc_valid(tx_desc_valid), .tx_desc_addr(tx_desc_addr), .tx_desc_len(tx_desc_len),
    .sent_core(sent_core), .sent_slot(sent_slot)
  );

endmodule

//--- logic/tx_desc_issuer.sv
`timescale 1ns/1ps

module tx_desc_issuer
  import slot_pkg::*, msg_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [63:0] msg_data,
  input  logic        msg_valid,
  input  core_no_t    msg_core_no,
  output logic        msg_ready,
  input  logic        tx_desc_ready,
  output logic        tx_desc_valid,
  output dma_addr_t   tx_desc_addr,
  output pkt_len_t    tx_desc_len,
  output core_no_t    sent_core,
  output slot_no_t    sent_slot
);

  tx_state_e   state;
  msg_len_t    msg_len;
  msg_slot_t   msg_slot;
  msg_offset_t msg_offset;
  logic        accept;

  assign msg_len    = msg_data[15:0];
  assign msg_slot   = msg_data[31:24];
  assign msg_offset = msg_data[47:32];

  assign msg_ready = tx_desc_ready && (state == TX_IDLE);
  assign accept    = msg_valid && msg_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= TX_IDLE;
    end else if (state == TX_PULSE) begin
      state <= TX_IDLE;
    end else if (accept && (msg_len != '0)) begin
      // zero length means the core dropped the packet
      state <= TX_PULSE;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      tx_desc_addr <= {msg_core_no, msg_offset};
      tx_desc_len  <= msg_len;
      sent_core    <= msg_core_no;
      sent_slot    <= msg_slot[$bits(slot_no_t)-1:0];
    end
  end

  assign tx_desc_valid = (state == TX_PULSE);

endmodule

//--- logic/rx_desc_builder.sv
`timescale 1ns/1ps
`include "dma_cfg.svh"

module rx_desc_builder
  import slot_pkg::*, msg_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   free_valid,
  input  core_no_t               free_core,
  input  slot_no_t               free_slot,
  output logic                   free_pop,
  input  logic                   incoming_pkt,
  input  logic [`CORE_COUNT-1:0] drop_list,
  input  logic                   drop_list_valid,
  input  pkt_len_t               max_pkt_len,
  input  logic                   max_pkt_len_valid,
  input  slot_no_t               slot_addr_wr_no,
  input  slot_addr_t             slot_addr_wr_data,
  input  logic                   slot_addr_wr_valid,
  input  logic                   rx_desc_ready,
  output logic                   rx_desc_valid,
  output dma_addr_t              rx_desc_addr,
  output pkt_len_t               rx_desc_len
);

  localparam int PAD_W = `CORE_ADDR_WIDTH - $bits(slot_addr_t) - `SLOT_LEAD_ZERO;

  logic [`CORE_COUNT-1:0] drop_list_r;
  pkt_len_t               max_len_r;
  slot_addr_t             slot_table [`SLOT_COUNT];
  stage_state_e           stage;
  core_no_t               stage_core;
  slot_addr_t             stage_addr;
  logic [9:0]             wait_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      drop_list_r <= '0;
      max_len_r   <= pkt_len_t'(`DEF_MAX_PKT_LEN);
    end else begin
      if (drop_list_valid) begin
        drop_list_r <= drop_list;
      end
      if (max_pkt_len_valid) begin
        max_len_r <= max_pkt_len;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (slot_addr_wr_valid) begin
      slot_table[slot_addr_wr_no] <= slot_addr_wr_data;
    end
  end

  assign free_pop = (stage == STAGE_EMPTY) && free_valid;

  // a packet is either counted already or arriving right now
  assign rx_desc_valid = (stage == STAGE_FULL) && rx_desc_ready &&
                         ((wait_cnt != 10'd0) || incoming_pkt);

  always_ff @(posedge clk) begin
    if (rst) begin
      stage <= STAGE_EMPTY;
    end else begin
      case (stage)
        STAGE_EMPTY: if (free_pop) stage <= drop_list_r[free_core] ? STAGE_DROP : STAGE_FULL;
        STAGE_FULL:  if (rx_desc_valid) stage <= STAGE_EMPTY;
        default:     stage <= STAGE_EMPTY;
      endcase
    end
  end

  // table lookup happens with the pop
  always_ff @(posedge clk) begin
    if (free_pop) begin
      stage_core <= free_core;
      stage_addr <= slot_table[free_slot];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= 10'd0;
    end else if (rx_desc_valid && !incoming_pkt) begin
      wait_cnt <= wait_cnt - 10'd1;
    end else if (incoming_pkt && !rx_desc_valid) begin
      wait_cnt <= wait_cnt + 10'd1;
    end
  end

  assign rx_desc_addr = {stage_core, {PAD_W{1'b0}}, stage_addr, `RX_WRITE_OFFSET};
  assign rx_desc_len  = max_len_r;

  // waiting counter must not wrap
  a_wait_no_wrap: assert property (@(posedge clk) disable iff (rst)
    incoming_pkt && !rx_desc_valid |-> wait_cnt != '1)
    else $error("rx_desc_builder: waiting packet counter overflow");

endmodule

//--- logic/slot_recycler.sv
`timescale 1ns/1ps
`include "dma_cfg.svh"

module slot_recycler
  import slot_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     sent_valid,
  input  core_no_t sent_core,
  input  slot_no_t sent_slot,
  input  logic     pkt_sent_out,
  input  core_no_t inject_desc_core,
  input  slot_no_t inject_desc_slot,
  input  logic     inject_desc_valid,
  output logic     inject_desc_ready,
  output logic     free_valid,
  output core_no_t free_core,
  output slot_no_t free_slot,
  input  logic     free_pop
);

  localparam int ENTRY_W = $bits(core_no_t) + $bits(slot_no_t);

  logic [ENTRY_W-1:0] ret_entry;
  logic               inflight_empty;
  logic [ENTRY_W-1:0] free_din;
  logic [ENTRY_W-1:0] free_dout;
  logic               free_push;
  logic               free_full;
  logic               free_empty;

  // transmitted slots wait here until the MAC says they left
  desc_fifo #(
    .ADDR_WIDTH(`INFLIGHT_DEPTH_LOG2),
    .DATA_WIDTH(ENTRY_W)
  ) inflight_fifo (
    .clk  (clk),
    .rst  (rst),
    .push (sent_valid),
    .din  ({sent_core, sent_slot}),
    .full (),
    .pop  (pkt_sent_out),
    .dout (ret_entry),
    .empty(inflight_empty)
  );

  // returned slot has priority, injection only gets the free cycles
  assign inject_desc_ready = !pkt_sent_out && !free_full;
  assign free_push = pkt_sent_out || (inject_desc_valid && inject_desc_ready);
  assign free_din  = pkt_sent_out ? ret_entry : {inject_desc_core, inject_desc_slot};

  desc_fifo #(
    .ADDR_WIDTH(`FREE_FIFO_DEPTH_LOG2),
    .DATA_WIDTH(ENTRY_W)
  ) free_fifo (
    .clk  (clk),
    .rst  (rst),
    .push (free_push),
    .din  (free_din),
    .full (free_full),
    .pop  (free_pop),
    .dout (free_dout),
    .empty(free_empty)
  );

  assign free_valid = !free_empty;
  assign {free_core, free_slot} = free_dout;

  a_sent_has_owner: assert property (@(posedge clk) disable iff (rst)
    pkt_sent_out |-> !inflight_empty)
    else $error("slot_recycler: MAC reported a sent packet with nothing in flight");

endmodule

//--- logic/desc_fifo.sv
`timescale 1ns/1ps

module desc_fifo #(
  parameter int ADDR_WIDTH = 4,
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  logic [DATA_WIDTH-1:0] din,
  output logic                  full,
  input  logic                  pop,
  output logic [DATA_WIDTH-1:0] dout,
  output logic                  empty
);

  localparam logic [ADDR_WIDTH:0] PTR_STEP = 1;

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  // extra top bit tells full from empty
  logic [ADDR_WIDTH:0] wr_ptr;
  logic [ADDR_WIDTH:0] rd_ptr;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + PTR_STEP;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + PTR_STEP;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[ADDR_WIDTH-1:0]] <= din;
    end
  end

  // head of queue is always visible
  assign dout  = mem[rd_ptr[ADDR_WIDTH-1:0]];
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                 (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("desc_fifo: push while full");
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
    else $error("desc_fifo: pop while empty");

endmodule

//--- logic/msg_pkg.sv
package msg_pkg;

  // fields of the 64-bit core message
  // [15:0] length, [23:16] port (unused), [31:24] slot, [47:32] read address
  typedef logic [15:0] msg_len_t;
  typedef logic [7:0]  msg_slot_t;
  typedef logic [15:0] msg_offset_t;

  typedef enum logic {
    TX_IDLE,
    TX_PULSE
  } tx_state_e;

  // rx staging register contents
  typedef enum logic [1:0] {
    STAGE_EMPTY,
    STAGE_FULL,
    STAGE_DROP
  } stage_state_e;

endpackage

//--- logic/slot_pkg.sv
`include "dma_cfg.svh"

package slot_pkg;

  typedef logic [$clog2(`CORE_COUNT)-1:0] core_no_t;
  typedef logic [$clog2(`SLOT_COUNT)-1:0] slot_no_t;

  // slot base without the top zero bit and the aligned low bits
  typedef logic [`CORE_ADDR_WIDTH-1-`SLOT_LEAD_ZERO-1:0] slot_addr_t;

  // core number on top of the core-local address
  typedef logic [$clog2(`CORE_COUNT)+`CORE_ADDR_WIDTH-1:0] dma_addr_t;

  typedef logic [`LEN_WIDTH-1:0] pkt_len_t;

endpackage

//--- include/dma_cfg.svh
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// core and slot geometry
`define CORE_COUNT       16
`define SLOT_COUNT       16

// address bits inside one core's memory window
`define CORE_ADDR_WIDTH  16

// slot bases are aligned, so these low bits are always zero
`define SLOT_LEAD_ZERO   8

// received data starts this far into the slot
`define RX_WRITE_OFFSET  8'h0A

// packet length
`define LEN_WIDTH        16
`define DEF_MAX_PKT_LEN  2048

// queue depths, log2
`define FREE_FIFO_DEPTH_LOG2  8
`define INFLIGHT_DEPTH_LOG2   2

`endif
